// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module robTb -Mdir obj_dir -f files.f
	./obj_dir/VrobTb > sim.log 2>&1; cat sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: files.f
robPkg.sv
robAlloc.sv
robStore.sv
robCommit.sv
robTop.sv
robTop_sva.sv
robTb.sv

// File: robAlloc.sv
`timescale 1ns/1ps
`default_nettype none

module robAlloc (
    input  logic               clk,
    input  logic               rst,
    input  robPkg::RenameUop   rnUop[robPkg::RN_WIDTH-1:0],
    input  logic               flush,
    input  robPkg::SqN         flushHead,
    output robPkg::AllocWr     allocWr[robPkg::RN_WIDTH-1:0],
    output robPkg::SqN         tail
);
    import robPkg::*;

    SqN slotSqN[RN_WIDTH-1:0];
    logic [$clog2(RN_WIDTH+1)-1:0] acceptCnt;

    // Valid uops get consecutive sequence numbers starting at the tail
    always_comb begin
        acceptCnt = '0;
        for (int i = 0; i < RN_WIDTH; i++) begin
            slotSqN[i] = tail + SqN'(acceptCnt);
            allocWr[i] = '0;
            allocWr[i].valid = rnUop[i].valid && !flush;
            allocWr[i].idx = slotSqN[i][ID_LEN-1:0];
            allocWr[i].entry.tag = rnUop[i].tag;
            allocWr[i].entry.fetchId = rnUop[i].fetchId;
            allocWr[i].entry.sqnMsb = slotSqN[i][ID_LEN];
            if (rnUop[i].isTrap) begin
                // Trap known at decode so the entry starts out complete
                allocWr[i].entry.dst.cause = rnUop[i].dst.cause;
                allocWr[i].flags = FLAGS_TRAP;
            end else begin
                allocWr[i].entry.dst.rd = rnUop[i].dst.rd;
                allocWr[i].flags = FLAGS_NX;
            end
            if (allocWr[i].valid) begin
                acceptCnt = acceptCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tail <= '0;
        end else if (flush) begin
            // Younger entries are dropped and allocation resumes after the trap
            tail <= flushHead;
        end else begin
            tail <= tail + SqN'(acceptCnt);
        end
    end

endmodule

`default_nettype wire

// File: robCommit.sv
`timescale 1ns/1ps
`default_nettype none

module robCommit (
    input  logic                      clk,
    input  logic                      rst,
    input  robPkg::RobEntry           headEntries[robPkg::COM_WIDTH-1:0],
    input  robPkg::RobFlags           headFlags[robPkg::COM_WIDTH-1:0],
    input  robPkg::SqN                tail,
    output robPkg::SqN                head,
    output robPkg::CommitUop          comUop[robPkg::COM_WIDTH-1:0],
    output robPkg::TrapUop            trapUop,
    output logic                      flush,
    output robPkg::SqN                flushHead,
    output logic [robPkg::ID_LEN:0]   creditReturn,
    output logic [1:0]                retireCount
);
    import robPkg::*;

    CommitUop comNext[COM_WIDTH-1:0];
    TrapUop trapNext;
    logic [1:0] retCnt;
    logic scanStop;
    SqN slotSqN;
    logic slotLive;
    logic slotTrap;

    // In-order scan of the head window
    always_comb begin
        for (int i = 0; i < COM_WIDTH; i++) begin
            comNext[i] = '0;
        end
        trapNext = '0;
        retCnt = '0;
        slotSqN = head;
        slotLive = 1'b0;
        slotTrap = 1'b0;

        // Hold off while a trap is reported and during its flush
        scanStop = trapUop.valid || flush;

        for (int i = 0; i < COM_WIDTH; i++) begin
            slotSqN = head + SqN'(i);
            slotLive = $signed(slotSqN - tail) < 0;
            slotTrap = headFlags[i] >= FLAGS_TRAP;

            // A trap only leaves from slot 0 so that it retires alone
            if (scanStop || !slotLive || headFlags[i] == FLAGS_NX || (slotTrap && i != 0)) begin
                scanStop = 1'b1;
            end else begin
                comNext[i].valid = 1'b1;
                comNext[i].sqN = {headEntries[i].sqnMsb, slotSqN[ID_LEN-1:0]};
                comNext[i].tag = headEntries[i].tag;
                comNext[i].isBranch = headFlags[i] == FLAGS_BRANCH;
                // Runtime traps drop their destination
                if (headFlags[i] > FLAGS_TRAP) begin
                    comNext[i].rd = '0;
                end else begin
                    comNext[i].rd = headEntries[i].dst.rd;
                end
                retCnt = retCnt + 1'b1;

                if (slotTrap) begin
                    trapNext.valid = 1'b1;
                    trapNext.sqN = comNext[i].sqN;
                    trapNext.flags = headFlags[i];
                    trapNext.fetchId = headEntries[i].fetchId;
                    if (headFlags[i] == FLAGS_TRAP) begin
                        trapNext.cause = headEntries[i].dst.cause;
                    end
                    scanStop = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        comUop <= comNext;
        trapUop <= trapNext;
        if (rst) begin
            for (int i = 0; i < COM_WIDTH; i++) begin
                comUop[i].valid <= 1'b0;
            end
            trapUop.valid <= 1'b0;
            head <= '0;
            flush <= 1'b0;
            retireCount <= '0;
        end else begin
            head <= head + SqN'(retCnt);
            // Flush follows the trap report by exactly one cycle
            flush <= trapUop.valid;
            retireCount <= retCnt;
        end
    end

    // Head already sits just past the trap when the flush is raised
    assign flushHead = head;

    // During flush every entry between head and tail is freed at once
    assign creditReturn = flush ? (tail - head) : SqN'(retireCount);

endmodule

`default_nettype wire

// File: robPkg.sv
`default_nettype none

package robPkg;

    // Buffer geometry
    localparam int ROB_DEPTH = 16;
    localparam int ID_LEN = 4;
    localparam int RN_WIDTH = 2;
    localparam int COM_WIDTH = 2;
    localparam int WB_WIDTH = 2;

    // Entries are split over two banks by the low index bit
    localparam int BANK_DEPTH = ROB_DEPTH / 2;

    // One wrap bit above the index, so age compares as a signed difference
    typedef logic [ID_LEN:0] SqN;

    typedef logic [4:0] RegNm;
    typedef logic [4:0] TrapCause;
    typedef logic [5:0] Tag;
    typedef logic [7:0] FetchId;

    // Completion state of an entry where anything from FLAGS_TRAP upward is a trap
    typedef enum logic [2:0] {
        FLAGS_NX       = 3'd0,
        FLAGS_NONE     = 3'd1,
        FLAGS_BRANCH   = 3'd2,
        FLAGS_TRAP     = 3'd3,
        FLAGS_ILLEGAL  = 3'd4,
        FLAGS_MISALIGN = 3'd5
    } RobFlags;

    // Decode-time traps have no destination, so the field holds their cause
    typedef union packed {
        RegNm rd;
        TrapCause cause;
    } DstField;

    typedef struct packed {
        logic valid;
        DstField dst;
        Tag tag;
        logic isTrap;
        FetchId fetchId;
    } RenameUop;

    typedef struct packed {
        DstField dst;
        Tag tag;
        FetchId fetchId;
        logic sqnMsb;
    } RobEntry;

    typedef struct packed {
        logic valid;
        SqN sqN;
        RobFlags flags;
    } WbUop;

    typedef struct packed {
        logic valid;
        SqN sqN;
        RegNm rd;
        Tag tag;
        logic isBranch;
    } CommitUop;

    typedef struct packed {
        logic valid;
        SqN sqN;
        TrapCause cause;
        RobFlags flags;
        FetchId fetchId;
    } TrapUop;

    // One allocation write slot with the entry payload and its initial flag
    typedef struct packed {
        logic valid;
        logic [ID_LEN-1:0] idx;
        RobEntry entry;
        RobFlags flags;
    } AllocWr;

endpackage

`default_nettype wire

// File: robStore.sv
`timescale 1ns/1ps
`default_nettype none

module robStore (
    input  logic               clk,
    input  logic               rst,
    input  robPkg::AllocWr     allocWr[robPkg::RN_WIDTH-1:0],
    input  robPkg::WbUop       wbUop[robPkg::WB_WIDTH-1:0],
    input  logic               flush,
    input  robPkg::SqN         head,
    output robPkg::RobEntry    headEntries[robPkg::COM_WIDTH-1:0],
    output robPkg::RobFlags    headFlags[robPkg::COM_WIDTH-1:0]
);
    import robPkg::*;

    // Entry payload in two banks chosen by the low index bit
    RobEntry bankMem[1:0][BANK_DEPTH-1:0];

    // Completion flags written in order by allocation and out of order by writeback
    RobFlags flagMem[ROB_DEPTH-1:0];

    logic [ID_LEN-1:0] winIdx[COM_WIDTH-1:0];
    logic [ID_LEN-2:0] bankAddr[1:0];
    RobEntry bankOut[1:0];

    always_comb begin
        for (int i = 0; i < COM_WIDTH; i++) begin
            winIdx[i] = head[ID_LEN-1:0] + i[ID_LEN-1:0];
        end

        // The two window indices always fall in different banks
        bankAddr[0] = '0;
        bankAddr[1] = '0;
        for (int i = 0; i < COM_WIDTH; i++) begin
            bankAddr[winIdx[i][0]] = winIdx[i][ID_LEN-1:1];
        end

        for (int b = 0; b < 2; b++) begin
            bankOut[b] = bankMem[b][bankAddr[b]];
        end

        // Back into window order
        for (int i = 0; i < COM_WIDTH; i++) begin
            headEntries[i] = bankOut[winIdx[i][0]];
            headFlags[i] = flagMem[winIdx[i]];
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RN_WIDTH; i++) begin
            if (allocWr[i].valid) begin
                bankMem[allocWr[i].idx[0]][allocWr[i].idx[ID_LEN-1:1]] <= allocWr[i].entry;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                flagMem[i] <= FLAGS_NX;
            end
        end else begin
            for (int i = 0; i < RN_WIDTH; i++) begin
                if (allocWr[i].valid) begin
                    flagMem[allocWr[i].idx] <= allocWr[i].flags;
                end
            end
            // Results landing during a flush belong to dropped entries
            if (!flush) begin
                for (int i = 0; i < WB_WIDTH; i++) begin
                    if (wbUop[i].valid) begin
                        flagMem[wbUop[i].sqN[ID_LEN-1:0]] <= wbUop[i].flags;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: robTb.sv
`timescale 1ns/1ps
`default_nettype none

module robTb;
    import robPkg::*;

    logic clk;
    logic rst;
    RenameUop rnUop[RN_WIDTH-1:0];
    WbUop wbUop[WB_WIDTH-1:0];
    CommitUop comUop[COM_WIDTH-1:0];
    TrapUop trapUop;
    logic flush;
    logic [ID_LEN:0] creditReturn;
    logic [1:0] retireCount;

    // Stimulus and expectations of the current test
    RenameUop allocQ[$];
    WbUop wbQ[$];
    CommitUop expQ[$];
    CommitUop obsQ[$];
    TrapUop expTrap;
    TrapUop obsTrap;
    int expYounger;
    int flushCycles;
    int flushCredits;

    SqN base;
    logic completed[ROB_DEPTH];
    int credits;
    logic trapPrev;
    int errors;
    int cycles;
    int cycleLimit;
    logic [31:0] lcgState;

    robTop u_robTop (
        .clk          (clk),
        .rst          (rst),
        .rnUop        (rnUop),
        .wbUop        (wbUop),
        .comUop       (comUop),
        .trapUop      (trapUop),
        .flush        (flush),
        .creditReturn (creditReturn),
        .retireCount  (retireCount)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic compareVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic reportError(input string msg);
        $display("ERROR t=%0t %s", $time, msg);
        errors++;
    endtask

    task automatic clearInputs();
        for (int i = 0; i < RN_WIDTH; i++) begin
            rnUop[i] = '0;
        end
        for (int i = 0; i < WB_WIDTH; i++) begin
            wbUop[i] = '0;
        end
    endtask

    // Outputs change at the rising edge and are sampled at the falling one
    always @(negedge clk) begin : monitor
        logic [ID_LEN-1:0] rel;
        if (!rst) begin
            compareVal("retireCount", 32'(retireCount),
                32'(comUop[0].valid) + 32'(comUop[1].valid));
            compareVal("flush", 32'(flush), 32'(trapPrev));
            trapPrev = trapUop.valid;
            for (int s = 0; s < COM_WIDTH; s++) begin
                if (comUop[s].valid) begin
                    obsQ.push_back(comUop[s]);
                    rel = comUop[s].sqN[ID_LEN-1:0] - base[ID_LEN-1:0];
                    if (!completed[rel]) begin
                        reportError($sformatf("entry %0d retired before it completed",
                            comUop[s].sqN));
                    end
                end
            end
            if (trapUop.valid) begin
                obsTrap = trapUop;
            end
            if (flush) begin
                flushCycles++;
                flushCredits = int'(creditReturn);
            end
            credits = credits + int'(creditReturn);
            if (credits > ROB_DEPTH) begin
                reportError("the DUT returned more credits than were taken");
            end
        end
    end

    task automatic driveAllocs();
        int i;
        i = 0;
        while (i < allocQ.size()) begin
            @(negedge clk);
            clearInputs();
            // Rename holds back while the buffer flushes
            if (!flush) begin
                for (int s = 0; s < RN_WIDTH && i < allocQ.size(); s++) begin
                    if (credits == 0) begin
                        reportError("allocation attempted with no credit left");
                    end
                    rnUop[s] = allocQ[i];
                    completed[i] = allocQ[i].isTrap;
                    credits--;
                    i++;
                end
            end
        end
    endtask

    task automatic driveWbs();
        int i;
        int j;
        WbUop tmp;
        // Fisher-Yates so completions arrive out of program order
        for (int k = wbQ.size() - 1; k > 0; k--) begin
            j = int'(nextRand() >> 8) % (k + 1);
            tmp = wbQ[k];
            wbQ[k] = wbQ[j];
            wbQ[j] = tmp;
        end
        i = 0;
        while (i < wbQ.size()) begin
            @(negedge clk);
            clearInputs();
            for (int s = 0; s < WB_WIDTH && i < wbQ.size(); s++) begin
                wbUop[s] = wbQ[i];
                completed[wbQ[i].sqN[ID_LEN-1:0] - base[ID_LEN-1:0]] = 1'b1;
                i++;
            end
        end
        @(negedge clk);
        clearInputs();
    endtask

    task automatic runTest(input int num);
        int startErrors;
        int cnt;
        startErrors = errors;
        obsQ.delete();
        obsTrap = '0;
        flushCycles = 0;
        for (int k = 0; k < ROB_DEPTH; k++) begin
            completed[k] = 1'b0;
        end
        driveAllocs();
        driveWbs();
        // Wait for the last expected retirement and the flush after a trap
        while (obsQ.size() < expQ.size() || flushCycles < int'(expTrap.valid)) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        compareVal("retired count", obsQ.size(), expQ.size());
        cnt = (obsQ.size() < expQ.size()) ? obsQ.size() : expQ.size();
        for (int k = 0; k < cnt; k++) begin
            compareVal("comUop", 32'(obsQ[k]), 32'(expQ[k]));
        end
        compareVal("trapUop", 32'(obsTrap), 32'(expTrap));
        compareVal("flush cycles", flushCycles, 32'(expTrap.valid));
        if (expTrap.valid) begin
            compareVal("creditReturn during flush", flushCredits, expYounger);
        end
        compareVal("credits", credits, ROB_DEPTH);
        if (errors == startErrors) begin
            $display("test %0d ok with %0d retired", num, obsQ.size());
        end else begin
            $display("test %0d had %0d errors", num, errors - startErrors);
        end
        base = base + SqN'(expQ.size());
        allocQ.delete();
        wbQ.delete();
        expQ.delete();
        expTrap = '0;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycleLimit != 0 && cycles > cycleLimit) begin
            $display("timeout after %0d cycles with the DUT still busy", cycleLimit);
            $display("tests failed");
            $finish;
        end
    end

    initial begin : main
        int fd;
        int ch;
        int kind;
        int n;
        int lines;
        int numTests;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        RenameUop uop;
        WbUop wb;
        CommitUop ce;
        lcgState = 32'h4698e3a0;
        errors = 0;
        cycles = 0;
        cycleLimit = 0;
        lines = 0;
        numTests = 0;
        credits = ROB_DEPTH;
        base = '0;
        trapPrev = 1'b0;
        expTrap = '0;
        obsTrap = '0;
        flushCycles = 0;
        rst = 1'b1;
        clearInputs();

        fd = $fopen("robTests.txt", "r");
        if (fd == 0) begin
            reportError("cannot open robTests.txt");
        end else begin
            ch = $fgetc(fd);
            while (ch != -1) begin
                if (ch == 10) begin
                    lines++;
                end
                ch = $fgetc(fd);
            end
            $fclose(fd);
            fd = $fopen("robTests.txt", "r");
            cycleLimit = lines * 20;
        end

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        while (fd != 0 && $fscanf(fd, " %c", kind) == 1) begin
            case (kind)
                "#": begin
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end
                "A": begin
                    n = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                    if (n != 4) begin
                        reportError("allocate line in robTests.txt is missing fields");
                    end
                    uop = '0;
                    uop.valid = 1'b1;
                    uop.dst.rd = a[4:0];
                    uop.tag = b[5:0];
                    uop.isTrap = c[0];
                    uop.fetchId = d[7:0];
                    allocQ.push_back(uop);
                end
                "W": begin
                    n = $fscanf(fd, "%h %h", a, b);
                    if (n != 2) begin
                        reportError("writeback line in robTests.txt is missing fields");
                    end
                    wb = '{1'b1, base + SqN'(a), RobFlags'(b[2:0])};
                    wbQ.push_back(wb);
                end
                "R": begin
                    n = $fscanf(fd, "%h %h %h", a, b, c);
                    if (n != 3) begin
                        reportError("retire line in robTests.txt is missing fields");
                    end
                    ce = '{1'b1, base + SqN'(a), RegNm'(b), allocQ[a].tag, c[0]};
                    expQ.push_back(ce);
                end
                "X": begin
                    n = $fscanf(fd, "%h %h %h", a, b, c);
                    if (n != 3) begin
                        reportError("trap line in robTests.txt is missing fields");
                    end
                    expTrap = '{1'b1, base + SqN'(a), TrapCause'(b), RobFlags'(c[2:0]),
                        allocQ[a].fetchId};
                    expYounger = allocQ.size() - int'(a) - 1;
                end
                "E": begin
                    numTests++;
                    runTest(numTests);
                end
                default: begin
                    reportError("unknown line kind in robTests.txt");
                end
            endcase
        end

        $display("%0d tests run, %0d errors", numTests, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: robTests.txt
# Columns A dst tag isTrap fetchId / W rel flags / R rel rd isBranch / X rel cause flags / E runs
# Fields are hex and rel counts uops from the test start; flags 1 done 2 branch 4 illegal 5 misalign
# In-order retirement of shuffled completions with a branch
A 01 01 0 10
A 02 02 0 11
A 03 03 0 12
A 04 04 0 13
W 0 1
W 1 2
W 2 1
W 3 1
R 0 01 0
R 1 02 1
R 2 03 0
R 3 04 0
E
# Decode-time trap behind an incomplete entry and two younger uops flushed
A 07 08 0 20
A 0c 09 1 21
A 09 0a 0 22
A 0a 0b 0 23
W 0 1
R 0 07 0
R 1 0c 0
X 1 0c 3
E
# Runtime trap retires with rd 0 and one younger uop flushed
A 11 10 0 30
A 12 11 0 31
A 13 12 0 32
W 0 1
W 1 4
R 0 11 0
R 1 00 0
X 1 00 4
E

// File: robTop.sv
`timescale 1ns/1ps
`default_nettype none

module robTop (
    input  logic                      clk,
    input  logic                      rst,
    input  robPkg::RenameUop          rnUop[robPkg::RN_WIDTH-1:0],
    input  robPkg::WbUop              wbUop[robPkg::WB_WIDTH-1:0],
    output robPkg::CommitUop          comUop[robPkg::COM_WIDTH-1:0],
    output robPkg::TrapUop            trapUop,
    output logic                      flush,
    output logic [robPkg::ID_LEN:0]   creditReturn,
    output logic [1:0]                retireCount
);
    import robPkg::*;

    AllocWr allocWr[RN_WIDTH-1:0];
    SqN tail;
    SqN head;
    SqN flushHead;
    RobEntry headEntries[COM_WIDTH-1:0];
    RobFlags headFlags[COM_WIDTH-1:0];

    robAlloc u_robAlloc (
        .clk       (clk),
        .rst       (rst),
        .rnUop     (rnUop),
        .flush     (flush),
        .flushHead (flushHead),
        .allocWr   (allocWr),
        .tail      (tail)
    );

    robStore u_robStore (
        .clk         (clk),
        .rst         (rst),
        .allocWr     (allocWr),
        .wbUop       (wbUop),
        .flush       (flush),
        .head        (head),
        .headEntries (headEntries),
        .headFlags   (headFlags)
    );

    robCommit u_robCommit (
        .clk          (clk),
        .rst          (rst),
        .headEntries  (headEntries),
        .headFlags    (headFlags),
        .tail         (tail),
        .head         (head),
        .comUop       (comUop),
        .trapUop      (trapUop),
        .flush        (flush),
        .flushHead    (flushHead),
        .creditReturn (creditReturn),
        .retireCount  (retireCount)
    );

endmodule

`default_nettype wire

// File: robTop_sva.sv
`timescale 1ns/1ps
`default_nettype none

module robTop_sva (
    input logic                     clk,
    input logic                     rst,
    input robPkg::RenameUop         rnUop[robPkg::RN_WIDTH-1:0],
    input robPkg::CommitUop         comUop[robPkg::COM_WIDTH-1:0],
    input robPkg::TrapUop           trapUop,
    input logic                     flush,
    input logic [robPkg::ID_LEN:0]  creditReturn
);
    import robPkg::*;

    // Flush follows a trap report by one cycle and lasts one cycle
    flushAfterTrap: assert property (@(posedge clk) disable iff (rst)
        trapUop.valid |=> flush)
        else $error("trap report not followed by a flush");

    flushOnlyAfterTrap: assert property (@(posedge clk) disable iff (rst)
        flush |-> $past(trapUop.valid))
        else $error("flush without a trap report the cycle before");

    flushOneCycle: assert property (@(posedge clk) disable iff (rst)
        flush |=> !flush)
        else $error("flush held for more than one cycle");

    slotOrder: assert property (@(posedge clk) disable iff (rst)
        comUop[1].valid |-> comUop[0].valid)
        else $error("commit slot 1 valid without slot 0");

    creditBound: assert property (@(posedge clk) disable iff (rst)
        creditReturn <= ROB_DEPTH)
        else $error("creditReturn above buffer depth");

    noRenameOnFlush: assert property (@(posedge clk) disable iff (rst)
        flush |-> !(rnUop[0].valid || rnUop[1].valid))
        else $error("rename uop sent during flush");

endmodule

bind robTop robTop_sva u_robTopSva (.*);

`default_nettype wire
